/* files.f */
design/pipe_pkg.sv
design/pipe_start_fsm.sv
design/pipe_ring_buffer.sv
design/pipe_segment.sv
design/pipeline_gen.sv
verification/pipe_clk_gen.sv
verification/tb_pipeline_gen.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_pipeline_gen
log=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	--top-module "$top" -f files.f -o "$top"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q ">>> FAIL" "$log"; then
	echo "Simulation reported failure, see $log"
	exit 1
fi
if ! grep -q ">>> PASS" "$log"; then
	echo "Simulation ended without a result, see $log"
	exit 1
fi
exit 0

/* verification/tb_pipeline_gen.sv */
`timescale 1ns/1ps

module tb_pipeline_gen;

	localparam int n_tests         = 6;
	localparam int max_test_cycles = 1200;
	localparam int clk_period_ns   = 4;
	localparam int margin_cycles   = 200;
	localparam int hist_len        = 1024;  // Longer than the deepest delay

	logic                    CLK160;
	logic                    trst;
	pipe_pkg::daq_sample_t   daq_in0;
	pipe_pkg::daq_sample_t   daq_in1;
	pipe_pkg::pdepth_t       pdepth;
	logic                    restart;
	logic [1:0]              restart_seg;
	logic                    inj_sel;
	logic                    inj_pulse;
	pipe_pkg::group_out_t    grp_out;
	pipe_pkg::group_status_t grp_status;

	int                    seed = 32'h3997a86e;
	int                    edge_cnt;
	int                    mismatch_cnt = 0;
	int                    fail_cnt = 0;
	pipe_pkg::daq_sample_t hist_in [2][hist_len];  // Driven samples per edge
	logic                  hist_sel [hist_len];
	logic                  hist_pulse [hist_len];
	logic [1:0]            check_on = 2'b00;
	int                    depth_ref [2];
	logic                  inj_mode = 1'b0;
	logic                  pend_restart = 1'b0;
	logic [1:0]            pend_restart_seg = 2'b00;

	pipe_clk_gen u_clk (
		.CLK160 (CLK160),
		.trst   (trst)
	);

	pipeline_gen DUT (
		.CLK160      (CLK160),
		.trst        (trst),
		.daq_in0     (daq_in0),
		.daq_in1     (daq_in1),
		.pdepth      (pdepth),
		.restart     (restart),
		.restart_seg (restart_seg),
		.inj_sel     (inj_sel),
		.inj_pulse   (inj_pulse),
		.grp_out     (grp_out),
		.grp_status  (grp_status)
	);

	always @(posedge CLK160 or posedge trst) begin
		if (trst)
			edge_cnt <= 0;
		else
			edge_cnt <= edge_cnt + 1;  // Rising edges since reset release
	end

	////////////////////
	// Compare tasks
	////////////////////
	task automatic compare_sample(input pipe_pkg::daq_sample_t got,
			input pipe_pkg::daq_sample_t exp, input string name);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got %h expected %h at edge %0d", name, got, exp, edge_cnt);
		end
	endtask

	task automatic compare_status(input pipe_pkg::seg_status_t got,
			input pipe_pkg::seg_status_t exp, input string name);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: got %h expected %h at edge %0d", name, got, exp, edge_cnt);
		end
	endtask

	function automatic pipe_pkg::seg_status_t make_status(input logic run, input int occ);
		pipe_pkg::seg_status_t s;
		s.running = run;
		s.occ     = pipe_pkg::occ_t'(occ);
		return s;
	endfunction

	// Reference delay model with bit 0 taken from the injection history
	function automatic pipe_pkg::daq_sample_t expected_sample(input int seg, input int idx);
		int                    slot;
		pipe_pkg::daq_sample_t s;
		slot = idx % hist_len;
		s = hist_in[seg][slot];
		if (hist_sel[slot])
			s[0] = hist_pulse[slot];
		return s;
	endfunction

	function automatic logic seg_running(input int seg);
		return (seg == 1) ? grp_status.st1.running : grp_status.st0.running;
	endfunction

	////////////////////
	// Stimulus
	////////////////////
	task automatic draw_sample(output pipe_pkg::daq_sample_t s);
		s = {$random(seed), $random(seed), $random(seed)};
	endtask

	// Drives the values for the next rising edge and records them under its number
	task automatic drive_next();
		int                    slot;
		int                    r;
		pipe_pkg::daq_sample_t s0;
		pipe_pkg::daq_sample_t s1;
		slot = (edge_cnt + 1) % hist_len;
		draw_sample(s0);
		draw_sample(s1);
		r = $random(seed);
		daq_in0          = s0;
		daq_in1          = s1;
		inj_sel          = inj_mode;
		inj_pulse        = r[0];
		restart          = pend_restart;
		restart_seg      = pend_restart_seg;
		pend_restart     = 1'b0;  // One-cycle pulse
		pend_restart_seg = 2'b00;
		hist_in[0][slot] = s0;
		hist_in[1][slot] = s1;
		hist_sel[slot]   = inj_mode;
		hist_pulse[slot] = r[0];
	endtask

	task automatic check_outputs();
		if (check_on[0]) begin
			compare_sample(grp_out.seg0, expected_sample(0, edge_cnt - depth_ref[0] - 2),
				"grp_out.seg0");
			compare_status(grp_status.st0, make_status(1'b1, depth_ref[0]), "grp_status.st0");
		end
		if (check_on[1]) begin
			compare_sample(grp_out.seg1, expected_sample(1, edge_cnt - depth_ref[1] - 2),
				"grp_out.seg1");
			compare_status(grp_status.st1, make_status(1'b1, depth_ref[1]), "grp_status.st1");
		end
	endtask

	task automatic advance_cycle();
		@(negedge CLK160);
		check_outputs();
		drive_next();
	endtask

	// Output is valid two edges after running shows up
	task automatic arm_checks(input logic [1:0] mask);
		advance_cycle();
		advance_cycle();
		check_on = check_on | mask;
	endtask

	task automatic wait_running(input int seg, input int limit);
		int n;
		n = 0;
		while (!seg_running(seg) && n < limit) begin
			advance_cycle();
			n++;
		end
		if (!seg_running(seg)) begin
			fail_cnt++;
			$display("segment %0d did not start running within %0d cycles", seg, limit);
		end
	endtask

	// Leaves the caller one edge after the restart was seen
	task automatic restart_pulse(input logic shared, input logic [1:0] seg);
		pend_restart     = shared;
		pend_restart_seg = seg;
		advance_cycle();
		advance_cycle();
	endtask

	////////////////////
	// Directed tests
	////////////////////
	task automatic after_reset();
		compare_status(grp_status.st0, make_status(1'b0, 0), "grp_status.st0");
		compare_status(grp_status.st1, make_status(1'b0, 0), "grp_status.st1");
		depth_ref[0] = 20;
		depth_ref[1] = 20;
		wait_running(0, pipe_pkg::preset_cycles + 20 + 1);
		wait_running(1, pipe_pkg::preset_cycles + 20 + 1);
		compare_status(grp_status.st0, make_status(1'b1, 20), "grp_status.st0");
		compare_status(grp_status.st1, make_status(1'b1, 20), "grp_status.st1");
	endtask

	task automatic fixed_delay();
		arm_checks(2'b11);
		repeat (300) advance_cycle();
	endtask

	task automatic depth_change();
		pdepth = pipe_pkg::pdepth_t'(100);
		repeat (150) advance_cycle();  // Old depth still in force
		check_on = 2'b00;
		restart_pulse(1'b1, 2'b00);
		depth_ref[0] = 100;
		depth_ref[1] = 100;
		wait_running(0, pipe_pkg::preset_cycles + 100 + 1);
		wait_running(1, pipe_pkg::preset_cycles + 100 + 1);
		compare_status(grp_status.st0, make_status(1'b1, 100), "grp_status.st0");
		compare_status(grp_status.st1, make_status(1'b1, 100), "grp_status.st1");
		arm_checks(2'b11);
		repeat (200) advance_cycle();
	endtask

	task automatic seg_restart();
		check_on[1] = 1'b0;
		restart_pulse(1'b0, 2'b10);  // Segment 0 stays checked
		compare_status(grp_status.st1, make_status(1'b0, depth_ref[1]), "grp_status.st1");
		wait_running(1, pipe_pkg::preset_cycles + depth_ref[1] + 1);
		compare_status(grp_status.st1, make_status(1'b1, depth_ref[1]), "grp_status.st1");
		arm_checks(2'b10);
		repeat (100) advance_cycle();
	endtask

	task automatic test_pulse_inject();
		inj_mode = 1'b1;
		repeat (300) advance_cycle();
		inj_mode = 1'b0;
		repeat (depth_ref[0] + 10) advance_cycle();
	endtask

	task automatic small_depth();
		int d;
		for (d = 0; d < 2; d++) begin
			pdepth = pipe_pkg::pdepth_t'(d);
			check_on = 2'b00;
			restart_pulse(1'b1, 2'b00);
			depth_ref[0] = pipe_pkg::min_depth;  // Raised from 0 or 1
			depth_ref[1] = pipe_pkg::min_depth;
			wait_running(0, pipe_pkg::preset_cycles + pipe_pkg::min_depth + 1);
			wait_running(1, pipe_pkg::preset_cycles + pipe_pkg::min_depth + 1);
			compare_status(grp_status.st0, make_status(1'b1, pipe_pkg::min_depth),
				"grp_status.st0");
			compare_status(grp_status.st1, make_status(1'b1, pipe_pkg::min_depth),
				"grp_status.st1");
			arm_checks(2'b11);
			repeat (60) advance_cycle();
		end
	endtask

	initial begin
		#((n_tests * max_test_cycles + margin_cycles) * clk_period_ns);
		$display("watchdog expired, the tests did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		daq_in0     = '0;
		daq_in1     = '0;
		pdepth      = pipe_pkg::pdepth_t'(20);
		restart     = 1'b0;
		restart_seg = 2'b00;
		inj_sel     = 1'b0;
		inj_pulse   = 1'b0;
		@(negedge trst);
		drive_next();
		after_reset();
		fixed_delay();
		depth_change();
		seg_restart();
		test_pulse_inject();
		small_depth();
		$display("summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* verification/pipe_clk_gen.sv */
`timescale 1ns/1ps

module pipe_clk_gen (
	output logic CLK160,
	output logic trst
);

	localparam int half_period  = 2;  // 4 ns clock
	localparam int reset_cycles = 8;

	initial begin
		CLK160 = 1'b0;
		forever #(half_period) CLK160 = ~CLK160;
	end

	initial begin
		trst = 1'b1;
		repeat (reset_cycles) @(posedge CLK160);
		@(negedge CLK160);
		trst = 1'b0;  // Release away from the rising edge
	end

endmodule

/* design/pipeline_gen.sv */
`timescale 1ns/1ps

module pipeline_gen (
	input  logic                         CLK160,
	input  logic                         trst,
	input  pipe_pkg::daq_sample_t        daq_in0,
	input  pipe_pkg::daq_sample_t        daq_in1,
	input  pipe_pkg::pdepth_t            pdepth,
	input  logic                         restart,
	input  logic [pipe_pkg::n_seg-1:0]   restart_seg,
	input  logic                         inj_sel,
	input  logic                         inj_pulse,
	output pipe_pkg::group_out_t         grp_out,
	output pipe_pkg::group_status_t      grp_status
);

	pipe_pkg::daq_sample_t pip0;
	pipe_pkg::daq_sample_t pip1;

	pipe_segment u_seg0 (
		.CLK160    (CLK160),
		.trst      (trst),
		.daq_in    (daq_in0),
		.pdepth    (pdepth),
		.restart   (restart | restart_seg[0]),  // Shared or own restart
		.inj_sel   (inj_sel),
		.inj_pulse (inj_pulse),
		.pip_out   (pip0),
		.status    (grp_status.st0)
	);

	pipe_segment u_seg1 (
		.CLK160    (CLK160),
		.trst      (trst),
		.daq_in    (daq_in1),
		.pdepth    (pdepth),
		.restart   (restart | restart_seg[1]),
		.inj_sel   (inj_sel),
		.inj_pulse (inj_pulse),
		.pip_out   (pip1),
		.status    (grp_status.st1)
	);

	////////////////////
	// Group output register
	////////////////////
	always_ff @(posedge CLK160) begin
		grp_out.seg1 <= pip1;
		grp_out.seg0 <= pip0;  // Low half of the group word
	end

endmodule

/* design/pipe_segment.sv */
`timescale 1ns/1ps

module pipe_segment (
	input  logic                  CLK160,
	input  logic                  trst,
	input  pipe_pkg::daq_sample_t daq_in,
	input  pipe_pkg::pdepth_t     pdepth,
	input  logic                  restart,
	input  logic                  inj_sel,
	input  logic                  inj_pulse,
	output pipe_pkg::daq_sample_t pip_out,
	output pipe_pkg::seg_status_t status
);

	logic                  buf_clr;
	logic                  wr_en;
	logic                  rd_en;
	pipe_pkg::daq_sample_t buf_din;
	pipe_pkg::daq_sample_t buf_dout;

	// Test pulse takes the place of bit 0
	assign buf_din = inj_sel ? {daq_in[pipe_pkg::sample_w-1:1], inj_pulse} : daq_in;

	pipe_start_fsm u_fsm (
		.CLK160  (CLK160),
		.trst    (trst),
		.pdepth  (pdepth),
		.restart (restart),
		.buf_clr (buf_clr),
		.wr_en   (wr_en),
		.rd_en   (rd_en),
		.status  (status)
	);

	pipe_ring_buffer u_buf (
		.CLK160  (CLK160),
		.trst    (trst),
		.buf_clr (buf_clr),
		.wr_en   (wr_en),
		.rd_en   (rd_en),
		.din     (buf_din),
		.dout    (buf_dout)
	);

	////////////////////
	// Output register
	////////////////////
	always_ff @(posedge CLK160) begin
		pip_out <= buf_dout;  // Total delay D+1
	end

endmodule

/* design/pipe_ring_buffer.sv */
`timescale 1ns/1ps

module pipe_ring_buffer (
	input  logic                  CLK160,
	input  logic                  trst,
	input  logic                  buf_clr,
	input  logic                  wr_en,
	input  logic                  rd_en,
	input  pipe_pkg::daq_sample_t din,
	output pipe_pkg::daq_sample_t dout
);

	pipe_pkg::daq_sample_t mem [pipe_pkg::mem_depth];
	pipe_pkg::buf_addr_t   wr_ptr;
	pipe_pkg::buf_addr_t   rd_ptr;

	////////////////////
	// Pointers
	////////////////////
	// Both wrap at the memory size and stay the depth apart
	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (buf_clr) begin
			wr_ptr <= '0;  // Clear during PRESET
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + pipe_pkg::buf_addr_t'(1);
			if (rd_en)
				rd_ptr <= rd_ptr + pipe_pkg::buf_addr_t'(1);
		end
	end

	////////////////////
	// Storage
	////////////////////
	always_ff @(posedge CLK160) begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	// Registered read port
	always_ff @(posedge CLK160) begin
		if (rd_en)
			dout <= mem[rd_ptr];  // Shows up one cycle later
	end

endmodule

/* design/pipe_start_fsm.sv */
`timescale 1ns/1ps

module pipe_start_fsm (
	input  logic                  CLK160,
	input  logic                  trst,
	input  pipe_pkg::pdepth_t     pdepth,
	input  logic                  restart,
	output logic                  buf_clr,
	output logic                  wr_en,
	output logic                  rd_en,
	output pipe_pkg::seg_status_t status
);

	pipe_pkg::pipe_state_t state;
	logic [1:0]            hold;       // Times the clear in PRESET
	pipe_pkg::pdepth_t     wcnt;       // Writes done in FILL
	pipe_pkg::pdepth_t     depth;      // Latched depth
	logic                  dep_valid;  // Depth taken since reset
	pipe_pkg::occ_t        occ;

	////////////////////
	// Depth latch
	////////////////////
	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			depth     <= pipe_pkg::pdepth_t'(pipe_pkg::min_depth);
			dep_valid <= 1'b0;
		end else if (restart || !dep_valid) begin
			dep_valid <= 1'b1;
			if (pdepth < pipe_pkg::pdepth_t'(pipe_pkg::min_depth))
				depth <= pipe_pkg::pdepth_t'(pipe_pkg::min_depth);  // Raise tiny depths
			else
				depth <= pdepth;
		end
	end

	////////////////////
	// State and counters
	////////////////////
	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			state <= pipe_pkg::PRESET;
			hold  <= '0;
			wcnt  <= '0;
		end else if (restart) begin
			state <= pipe_pkg::PRESET;  // Any restart starts over
			hold  <= '0;
			wcnt  <= '0;
		end else begin
			case (state)
				pipe_pkg::PRESET: begin
					hold <= hold + 2'd1;
					wcnt <= '0;
					if (hold == 2'(pipe_pkg::preset_cycles - 1))
						state <= pipe_pkg::FILL;
				end
				pipe_pkg::FILL: begin
					wcnt <= wcnt + pipe_pkg::pdepth_t'(1);
					if (wcnt == depth - pipe_pkg::pdepth_t'(1))
						state <= pipe_pkg::RUN;  // Last fill write
				end
				pipe_pkg::RUN: begin
					// Stays here until a restart
				end
				default: begin
					state <= pipe_pkg::PRESET;
				end
			endcase
		end
	end

	// Occupancy goes up on write only and down on read only
	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			occ <= '0;
		end else if (buf_clr) begin
			occ <= '0;
		end else begin
			case ({rd_en, wr_en})
				2'b01:   occ <= occ + pipe_pkg::occ_t'(1);
				2'b10:   occ <= occ - pipe_pkg::occ_t'(1);
				default: occ <= occ;
			endcase
		end
	end

	assign buf_clr = (state == pipe_pkg::PRESET);
	assign wr_en   = (state == pipe_pkg::FILL) || (state == pipe_pkg::RUN);
	assign rd_en   = (state == pipe_pkg::RUN);

	assign status.running = (state == pipe_pkg::RUN);
	assign status.occ     = occ;

endmodule

/* design/pipe_pkg.sv */
package pipe_pkg;

	////////////////////
	// Sizes and limits
	////////////////////
	localparam int sample_w      = 96;   // Eight channels of 12 bits
	localparam int depth_w       = 9;
	localparam int mem_depth     = 512;
	localparam int occ_w         = 10;
	localparam int preset_cycles = 4;    // Length of the buffer clear
	localparam int min_depth     = 2;    // Smaller settings are raised to this
	localparam int n_seg         = 2;

	typedef logic [sample_w-1:0]          daq_sample_t;
	typedef logic [depth_w-1:0]           pdepth_t;
	typedef logic [occ_w-1:0]             occ_t;
	typedef logic [$clog2(mem_depth)-1:0] buf_addr_t;

	typedef enum logic [1:0] {
		PRESET,  // Clear the buffer
		FILL,    // Write only, up to the depth
		RUN      // Write and read together
	} pipe_state_t;

	typedef struct packed {
		daq_sample_t seg1;
		daq_sample_t seg0;
	} group_out_t;

	typedef struct packed {
		logic running;
		occ_t occ;
	} seg_status_t;

	typedef struct packed {
		seg_status_t st1;
		seg_status_t st0;
	} group_status_t;

endpackage
